//--- logic/chart_pkg.sv
package chart_pkg;

    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;
    } note_t;

    // Player keys use the note layout
    typedef note_t keys_t;

    localparam logic [1:0] OCT_NONE = 2'd0;
    localparam logic [1:0] OCT_UP   = 2'd1;
    localparam logic [1:0] OCT_DOWN = 2'd2;

    typedef struct packed {
        logic       blank;
        logic [2:0] pitch;
        logic [1:0] octave;
    } seg_code_t;

    localparam seg_code_t SEG_BLANK = '{blank: 1'b1, pitch: 3'd0, octave: OCT_NONE};

    localparam int SCORE_W = 14;

    localparam logic [3:0] HIT_EXACT = 4'd10;
    localparam logic [3:0] HIT_LATE1 = 4'd10;
    localparam logic [3:0] HIT_LATE2 = 4'd8;
    localparam logic [3:0] HIT_LATE3 = 4'd5;

    // Half-periods at 100 MHz, C to B in rows: middle octave, up, down
    localparam logic [31:0] pitch_half_period [21] = '{
        32'd191110, 32'd170265, 32'd151685, 32'd143172,
        32'd127551, 32'd113636, 32'd101239,
        32'd95556,  32'd85132,  32'd75843,  32'd71586,
        32'd63776,  32'd56818,  32'd50619,
        32'd382219, 32'd340530, 32'd303370, 32'd286344,
        32'd255102, 32'd227273, 32'd202478
    };

    // 1 to 7 for a single key, 0 otherwise
    function automatic logic [2:0] note_pitch(note_t n);
        logic [2:0] p;
        p = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (n.keys == 7'(1 << i)) begin
                p = 3'(i + 1);
            end
        end
        return p;
    endfunction

    function automatic logic note_valid(note_t n);
        return (note_pitch(n) != 3'd0) && !(n.oct_up && n.oct_down);
    endfunction

    function automatic logic [1:0] note_octave(note_t n);
        if (n.oct_up) begin
            return OCT_UP;
        end
        if (n.oct_down) begin
            return OCT_DOWN;
        end
        return OCT_NONE;
    endfunction

endpackage

//--- logic/chart_mem.sv
module chart_mem #(
    parameter int CHART_LEN = 256,
    localparam int ADDR_W = (CHART_LEN > 1) ? $clog2(CHART_LEN) : 1
) (
    input  logic                prog_clk,
    input  logic                wr_en,
    input  logic [ADDR_W-1:0]   wr_addr,
    input  chart_pkg::note_t    wr_note,
    input  logic [ADDR_W-1:0]   rd_addr,
    output chart_pkg::note_t    rd_note
);

    chart_pkg::note_t mem [CHART_LEN];

    // One write port from the loader
    always_ff @(posedge prog_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_note;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge prog_clk) begin
        rd_note <= mem[rd_addr];
    end

endmodule

//--- logic/chart_mem_arbiter.sv
module chart_mem_arbiter #(
    parameter int CHART_LEN = 256,
    localparam int ADDR_W = (CHART_LEN > 1) ? $clog2(CHART_LEN) : 1
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              step_req,
    input  logic [ADDR_W-1:0] step_addr,
    input  logic              peek_req,
    input  logic [ADDR_W-1:0] peek_addr,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              step_valid,
    output logic              peek_valid
);

    typedef struct packed {
        logic step;
        logic peek;
    } grant_t;

    grant_t gnt;
    grant_t gnt_q;

    // Sequencer always wins, the display waits
    always_comb begin
        gnt.step = step_req;
        gnt.peek = peek_req & ~step_req;
    end

    assign mem_addr = gnt.step ? step_addr : peek_addr;

    // Read data belongs to whoever held the grant last cycle
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= gnt;
        end
    end

    assign step_valid = gnt_q.step;
    assign peek_valid = gnt_q.peek;

endmodule

//--- logic/play_sequencer.sv
module play_sequencer #(
    parameter int CHART_LEN   = 256,
    parameter int TICK_CYCLES = 1_000_000,
    parameter int COUNT_TICKS = 10,
    localparam int ADDR_W  = (CHART_LEN > 1) ? $clog2(CHART_LEN) : 1,
    localparam int TOTAL_W = $clog2(CHART_LEN + 1)
) (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                start,
    input  logic [TOTAL_W-1:0]  note_total,
    output logic                step_req,
    output logic [ADDR_W-1:0]   step_addr,
    input  logic                step_valid,
    input  chart_pkg::note_t    mem_note,
    output logic                step_tick,
    output chart_pkg::note_t    cur_note,
    output logic                cur_valid,
    output logic                playing,
    output logic                finished,
    output logic [1:0]          count_digit
);

    localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
    localparam int CT_W   = (COUNT_TICKS > 1) ? $clog2(COUNT_TICKS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COUNT,
        ST_PLAY,
        ST_DONE
    } state_t;

    state_t             state;
    logic [TICK_W-1:0]  tick_cnt;
    logic [CT_W-1:0]    digit_ticks;
    logic [TOTAL_W-1:0] step_cnt;
    chart_pkg::note_t   note_q;
    logic               tick_wrap;
    logic               start_ok;

    assign tick_wrap = (tick_cnt == TICK_W'(TICK_CYCLES - 1));
    assign start_ok  = start & ((state == ST_IDLE) | (state == ST_DONE));

    assign playing  = (state == ST_PLAY);
    assign finished = (state == ST_DONE);

    // No ticks once every note has been fetched
    assign step_tick = playing & tick_wrap & (step_cnt < note_total);
    assign step_req  = step_tick;
    assign step_addr = step_cnt[ADDR_W-1:0];

    // Fresh note shows straight from memory on its valid cycle
    assign cur_note  = step_valid ? mem_note : note_q;
    assign cur_valid = step_valid;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            tick_cnt    <= '0;
            digit_ticks <= '0;
            count_digit <= 2'd0;
            step_cnt    <= '0;
            note_q      <= '0;
        end else if (start_ok) begin
            state       <= ST_COUNT;
            tick_cnt    <= '0;
            digit_ticks <= '0;
            count_digit <= 2'd3;
            step_cnt    <= '0;
            note_q      <= '0;
        end else begin
            if (state == ST_COUNT || state == ST_PLAY) begin
                tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
            end
            // Countdown 3, 2, 1 then play
            if (state == ST_COUNT && tick_wrap) begin
                if (digit_ticks == CT_W'(COUNT_TICKS - 1)) begin
                    digit_ticks <= '0;
                    count_digit <= count_digit - 2'd1;
                    if (count_digit == 2'd1) begin
                        state <= ST_PLAY;
                    end
                end else begin
                    digit_ticks <= digit_ticks + 1'b1;
                end
            end
            if (step_tick) begin
                step_cnt <= step_cnt + 1'b1;
            end
            if (step_valid) begin
                note_q <= mem_note;
                if (step_cnt == note_total) begin
                    state <= ST_DONE;
                end
            end
        end
    end

endmodule

//--- logic/hit_judge.sv
module hit_judge (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           step_tick,
    input  chart_pkg::keys_t               keys,
    input  chart_pkg::note_t               cur_note,
    input  logic                           cur_valid,
    input  logic                           auto_play,
    output logic [chart_pkg::SCORE_W-1:0]  score
);

    // Index 0 is this tick, then one, two and three ticks back
    chart_pkg::keys_t            hist [4];
    logic [3:0]                  points;
    logic [chart_pkg::SCORE_W:0] sum;

    always_comb begin
        points = 4'd0;
        if (cur_note != '0) begin
            if (auto_play || cur_note == hist[0]) begin
                points = chart_pkg::HIT_EXACT;
            end else if (cur_note == hist[1]) begin
                points = chart_pkg::HIT_LATE1;
            end else if (cur_note == hist[2]) begin
                points = chart_pkg::HIT_LATE2;
            end else if (cur_note == hist[3]) begin
                points = chart_pkg::HIT_LATE3;
            end
        end
    end

    assign sum = {1'b0, score} + {{(chart_pkg::SCORE_W - 3){1'b0}}, points};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                hist[i] <= '0;
            end
            score <= '0;
        end else if (start) begin
            for (int i = 0; i < 4; i++) begin
                hist[i] <= '0;
            end
            score <= '0;
        end else begin
            if (step_tick) begin
                hist[0] <= keys;
                hist[1] <= hist[0];
                hist[2] <= hist[1];
                hist[3] <= hist[2];
            end
            if (cur_valid) begin
                // Saturate at all ones
                score <= sum[chart_pkg::SCORE_W] ? '1 : sum[chart_pkg::SCORE_W-1:0];
            end
        end
    end

endmodule

//--- logic/next_note_display.sv
module next_note_display #(
    parameter int CHART_LEN = 256,
    localparam int ADDR_W = (CHART_LEN > 1) ? $clog2(CHART_LEN) : 1
) (
    input  logic                  prog_clk,
    input  logic                  rst,
    input  logic                  playing,
    input  logic                  step_tick,
    input  logic [ADDR_W-1:0]     peek_base,
    output logic                  peek_req,
    output logic [ADDR_W-1:0]     peek_addr,
    input  logic                  peek_valid,
    input  chart_pkg::note_t      mem_note,
    output logic [7:0]            led,
    output chart_pkg::seg_code_t  seg
);

    logic                 got_ok;
    logic [ADDR_W-1:0]    sent_addr;
    logic [7:0]           led_map;
    chart_pkg::seg_code_t seg_map;

    // peek_base already points one past the note now sounding
    assign peek_addr = peek_base;

    // Held until data for the current base comes back
    assign peek_req = playing & ~got_ok;

    always_ff @(posedge prog_clk) begin
        sent_addr <= peek_addr;
    end

    // C on LED 7, octave shift on LED 0
    always_comb begin
        led_map = 8'd0;
        seg_map = chart_pkg::SEG_BLANK;
        if (chart_pkg::note_valid(mem_note)) begin
            led_map[0] = mem_note.oct_up | mem_note.oct_down;
            for (int i = 0; i < 7; i++) begin
                led_map[7 - i] = mem_note.keys[i];
            end
            seg_map.blank  = 1'b0;
            seg_map.pitch  = chart_pkg::note_pitch(mem_note);
            seg_map.octave = chart_pkg::note_octave(mem_note);
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            got_ok <= 1'b0;
            led    <= 8'd0;
            seg    <= chart_pkg::SEG_BLANK;
        end else if (!playing) begin
            // Countdown, idle and past the end all go dark
            got_ok <= 1'b0;
            led    <= 8'd0;
            seg    <= chart_pkg::SEG_BLANK;
        end else begin
            if (peek_valid) begin
                led    <= led_map;
                seg    <= seg_map;
                got_ok <= (sent_addr == peek_base);
            end
            // Base moves on each step, fetch again
            if (step_tick) begin
                got_ok <= 1'b0;
            end
        end
    end

endmodule

//--- logic/tone_gen.sv
module tone_gen #(
    parameter int TONE_SHIFT = 0
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  chart_pkg::note_t  cur_note,
    input  logic              playing,
    output logic              tone
);

    chart_pkg::note_t note_q;
    logic             sounding;
    logic [4:0]       idx;
    logic [31:0]      half;
    logic [31:0]      cnt;

    assign sounding = playing & chart_pkg::note_valid(cur_note);

    // Table rows of seven: middle, up, down
    always_comb begin
        idx = 5'd0;
        if (chart_pkg::note_valid(cur_note)) begin
            idx = 5'(chart_pkg::note_pitch(cur_note) - 3'd1)
                + 5'(7 * chart_pkg::note_octave(cur_note));
        end
    end

    assign half = chart_pkg::pitch_half_period[idx] >> TONE_SHIFT;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_q <= '0;
            cnt    <= '0;
            tone   <= 1'b0;
        end else if (!sounding || cur_note != note_q) begin
            note_q <= cur_note;
            cnt    <= '0;
            tone   <= 1'b0;
        end else if (cnt + 32'd1 >= half) begin
            cnt  <= '0;
            tone <= ~tone;
        end else begin
            cnt <= cnt + 32'd1;
        end
    end

endmodule

//--- logic/chart_player.sv
module chart_player #(
    parameter int CHART_LEN   = 256,
    parameter int TICK_CYCLES = 1_000_000,
    parameter int COUNT_TICKS = 10,
    parameter int TONE_SHIFT  = 0,
    localparam int ADDR_W  = (CHART_LEN > 1) ? $clog2(CHART_LEN) : 1,
    localparam int TOTAL_W = $clog2(CHART_LEN + 1)
) (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           load_en,
    input  logic [ADDR_W-1:0]              load_addr,
    input  chart_pkg::note_t               load_note,
    input  logic [TOTAL_W-1:0]             note_total,
    input  logic                           start,
    input  logic                           auto_play,
    input  chart_pkg::keys_t               keys,
    output logic [1:0]                     count_digit,
    output logic                           playing,
    output logic                           finished,
    output logic [chart_pkg::SCORE_W-1:0]  score,
    output logic                           tone,
    output logic [7:0]                     led,
    output chart_pkg::seg_code_t           seg
);

    logic              ctrl_idle;
    logic              start_ok;
    logic              wr_en;
    logic [ADDR_W-1:0] mem_addr;
    chart_pkg::note_t  rd_note;
    logic              step_req;
    logic [ADDR_W-1:0] step_addr;
    logic              step_valid;
    logic              peek_req;
    logic [ADDR_W-1:0] peek_addr;
    logic              peek_valid;
    logic              step_tick;
    chart_pkg::note_t  cur_note;
    logic              cur_valid;

    // Idle or finished: no countdown digit and not playing
    assign ctrl_idle = ~playing & (count_digit == 2'd0);
    assign wr_en     = load_en & ctrl_idle;
    assign start_ok  = start & ctrl_idle;

    chart_mem #(.CHART_LEN(CHART_LEN)) u_chart_mem (
        .prog_clk(prog_clk), .wr_en(wr_en), .wr_addr(load_addr),
        .wr_note(load_note), .rd_addr(mem_addr), .rd_note(rd_note)
    );

    chart_mem_arbiter #(.CHART_LEN(CHART_LEN)) u_arbiter (
        .prog_clk(prog_clk), .rst(rst),
        .step_req(step_req), .step_addr(step_addr),
        .peek_req(peek_req), .peek_addr(peek_addr),
        .mem_addr(mem_addr), .step_valid(step_valid), .peek_valid(peek_valid)
    );

    play_sequencer #(
        .CHART_LEN(CHART_LEN), .TICK_CYCLES(TICK_CYCLES), .COUNT_TICKS(COUNT_TICKS)
    ) u_sequencer (
        .prog_clk(prog_clk), .rst(rst), .start(start), .note_total(note_total),
        .step_req(step_req), .step_addr(step_addr),
        .step_valid(step_valid), .mem_note(rd_note),
        .step_tick(step_tick), .cur_note(cur_note), .cur_valid(cur_valid),
        .playing(playing), .finished(finished), .count_digit(count_digit)
    );

    hit_judge u_hit_judge (
        .prog_clk(prog_clk), .rst(rst), .start(start_ok), .step_tick(step_tick),
        .keys(keys), .cur_note(cur_note), .cur_valid(cur_valid),
        .auto_play(auto_play), .score(score)
    );

    next_note_display #(.CHART_LEN(CHART_LEN)) u_display (
        .prog_clk(prog_clk), .rst(rst), .playing(playing), .step_tick(step_tick),
        .peek_base(step_addr), .peek_req(peek_req), .peek_addr(peek_addr),
        .peek_valid(peek_valid), .mem_note(rd_note), .led(led), .seg(seg)
    );

    tone_gen #(.TONE_SHIFT(TONE_SHIFT)) u_tone_gen (
        .prog_clk(prog_clk), .rst(rst), .cur_note(cur_note),
        .playing(playing), .tone(tone)
    );

endmodule

//--- bench/chart_player_tb.sv
module chart_player_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CHART_LEN   = 32;
    localparam int TICK_CYCLES = 40;
    localparam int COUNT_TICKS = 2;
    localparam int TONE_SHIFT  = 8;
    localparam int ADDR_W      = $clog2(CHART_LEN);
    localparam int TOTAL_W     = $clog2(CHART_LEN + 1);
    localparam int PLAY0       = 3 * COUNT_TICKS * TICK_CYCLES;
    localparam int RUN_A       = 20;
    localparam int RUN_C       = 24;
    localparam int CYCLE_LIMIT = 3 * (PLAY0 + TICK_CYCLES) + (2 * RUN_A + RUN_C) * TICK_CYCLES
                               + 4 * CHART_LEN + 500;

    logic                          prog_clk;
    logic                          rst;
    logic                          load_en;
    logic [ADDR_W-1:0]             load_addr;
    chart_pkg::note_t              load_note;
    logic [TOTAL_W-1:0]            note_total;
    logic                          start;
    logic                          auto_play;
    chart_pkg::keys_t              keys;
    logic [1:0]                    count_digit;
    logic                          playing;
    logic                          finished;
    logic [chart_pkg::SCORE_W-1:0] score;
    logic                          tone;
    logic [7:0]                    led;
    chart_pkg::seg_code_t          seg;

    // Reference model state, snapshot taken at each accepted start
    chart_pkg::note_t              chart [CHART_LEN];
    chart_pkg::note_t              play_chart [CHART_LEN];
    chart_pkg::keys_t              key_log [CHART_LEN];
    logic                          active = 1'b0;
    logic                          auto_q = 1'b0;
    int                            age = 0;
    int                            n_q = 0;
    int                            cycles = 0;
    int                            mismatches = 0;
    int                            failures = 0;

    logic [1:0]                    exp_digit;
    logic                          exp_playing;
    logic                          exp_finished;
    logic [chart_pkg::SCORE_W-1:0] exp_score;
    logic [7:0]                    exp_led;
    chart_pkg::seg_code_t          exp_seg;
    logic                          led_chk;
    logic                          exp_tone;

    chart_player #(
        .CHART_LEN(CHART_LEN), .TICK_CYCLES(TICK_CYCLES),
        .COUNT_TICKS(COUNT_TICKS), .TONE_SHIFT(TONE_SHIFT)
    ) u_chart_player (
        .prog_clk(prog_clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_note(load_note), .note_total(note_total), .start(start),
        .auto_play(auto_play), .keys(keys), .count_digit(count_digit),
        .playing(playing), .finished(finished), .score(score), .tone(tone),
        .led(led), .seg(seg)
    );

    initial begin
        prog_clk = 1'b0;
        forever #20 prog_clk = ~prog_clk;
    end

    function automatic int pitch_of(chart_pkg::note_t n);
        int p;
        p = 0;
        if ($countones(n.keys) == 1 && !(n.oct_up && n.oct_down)) begin
            for (int i = 0; i < 7; i++) begin
                if (n.keys[i])
                    p = i + 1;
            end
        end
        return p;
    endfunction

    function automatic logic [7:0] led_of(chart_pkg::note_t n);
        logic [7:0] l;
        l = 8'd0;
        if (pitch_of(n) != 0) begin
            for (int i = 0; i < 7; i++)
                l[7 - i] = n.keys[i];
            l[0] = n.oct_up | n.oct_down;
        end
        return l;
    endfunction

    function automatic chart_pkg::seg_code_t seg_of(chart_pkg::note_t n);
        chart_pkg::seg_code_t s;
        s = '{blank: 1'b1, pitch: 3'd0, octave: 2'd0};
        if (pitch_of(n) != 0) begin
            s.blank  = 1'b0;
            s.pitch  = 3'(pitch_of(n));
            s.octave = n.oct_up ? 2'd1 : (n.oct_down ? 2'd2 : 2'd0);
        end
        return s;
    endfunction

    function automatic int hit_points(int s);
        int pts [4];
        int p;
        pts = '{10, 10, 8, 5};
        p = 0;
        if (play_chart[s] != '0) begin
            if (auto_q)
                p = 10;
            for (int b = 3; b >= 0; b--) begin
                if (!auto_q && s - b >= 0 && key_log[s - b] == play_chart[s])
                    p = pts[b];
            end
        end
        return p;
    endfunction

    function automatic int score_at(int a);
        int sum;
        sum = 0;
        for (int s = 0; s < n_q; s++) begin
            if (PLAY0 + TICK_CYCLES * (s + 1) + 1 <= a)
                sum += hit_points(s);
        end
        return (sum > (1 << chart_pkg::SCORE_W) - 1) ? (1 << chart_pkg::SCORE_W) - 1 : sum;
    endfunction

    // Note s restarts its square wave one cycle after it arrives
    function automatic logic tone_at(int a);
        int s;
        int s0;
        int half;
        logic t;
        t = 1'b0;
        if (a > PLAY0 + TICK_CYCLES && a <= PLAY0 + TICK_CYCLES * n_q + 1) begin
            s = (a - PLAY0 - TICK_CYCLES - 1) / TICK_CYCLES;
            if (pitch_of(play_chart[s]) != 0) begin
                s0 = s;
                while (s0 > 0 && play_chart[s0 - 1] == play_chart[s])
                    s0--;
                half = int'(chart_pkg::pitch_half_period[pitch_of(play_chart[s]) - 1
                    + (play_chart[s].oct_up ? 7 : (play_chart[s].oct_down ? 14 : 0))]
                    >> TONE_SHIFT);
                t = (((a - PLAY0 - TICK_CYCLES * (s0 + 1) - 1) / half) % 2) == 1;
            end
        end
        return t;
    endfunction

    always @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            age    <= 0;
        end else if (start && (!active || age > PLAY0 + TICK_CYCLES * n_q)) begin
            active     <= 1'b1;
            age        <= 0;
            n_q        <= int'(note_total);
            auto_q     <= auto_play;
            play_chart <= chart;
        end else begin
            age <= age + 1;
        end
    end

    always_comb begin
        int j;
        exp_digit    = 2'd0;
        exp_playing  = active && age >= PLAY0 && age <= PLAY0 + TICK_CYCLES * n_q;
        exp_finished = active && age > PLAY0 + TICK_CYCLES * n_q;
        exp_score    = active ? chart_pkg::SCORE_W'(score_at(age)) : '0;
        exp_led      = 8'd0;
        exp_seg      = seg_of('0);
        led_chk      = 1'b1;
        exp_tone     = active && tone_at(age);
        j            = 0;
        if (active && age < PLAY0)
            exp_digit = 2'(3 - age / (COUNT_TICKS * TICK_CYCLES));
        if (active && age >= PLAY0) begin
            // Next note lands within 3 cycles of each tick
            j       = (age - PLAY0) / TICK_CYCLES;
            led_chk = ((age - PLAY0) % TICK_CYCLES) >= 2;
            if (j < n_q) begin
                exp_led = led_of(play_chart[j]);
                exp_seg = seg_of(play_chart[j]);
            end
        end
    end

    task automatic report_mismatch(string name, longint expv, longint got);
        mismatches++;
        $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expv, got);
    endtask

    assert property (@(posedge prog_clk) disable iff (rst) count_digit == exp_digit)
        else report_mismatch("count_digit", $sampled(exp_digit), $sampled(count_digit));
    assert property (@(posedge prog_clk) disable iff (rst) playing == exp_playing)
        else report_mismatch("playing", $sampled(exp_playing), $sampled(playing));
    assert property (@(posedge prog_clk) disable iff (rst) finished == exp_finished)
        else report_mismatch("finished", $sampled(exp_finished), $sampled(finished));
    assert property (@(posedge prog_clk) disable iff (rst) score == exp_score)
        else report_mismatch("score", $sampled(exp_score), $sampled(score));
    assert property (@(posedge prog_clk) disable iff (rst) led_chk |-> led == exp_led)
        else report_mismatch("led", $sampled(exp_led), $sampled(led));
    assert property (@(posedge prog_clk) disable iff (rst) led_chk |-> seg == exp_seg)
        else report_mismatch("seg", $sampled(exp_seg), $sampled(seg));
    assert property (@(posedge prog_clk) disable iff (rst) tone == exp_tone)
        else report_mismatch("tone", $sampled(exp_tone), $sampled(tone));

    always @(posedge prog_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            failures++;
            $display("Run did not reach its end within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic wait_age(int n);
        while (age < n)
            @(negedge prog_clk);
    endtask

    task automatic make_random_chart();
        int r;
        int oct;
        for (int a = 0; a < CHART_LEN; a++) begin
            r        = $urandom % 12;
            oct      = $urandom % 3;
            chart[a] = '0;
            // Mostly single notes, some rests and some two-key entries
            if (r == 2) begin
                chart[a].keys = 7'b0000011 << ($urandom % 6);
            end else if (r > 2) begin
                chart[a].keys     = 7'd1 << ($urandom % 7);
                chart[a].oct_up   = (oct == 1);
                chart[a].oct_down = (oct == 2);
            end
        end
    endtask

    // Long runs of one pitch so the wave gets to toggle
    task automatic make_tone_chart();
        for (int a = 0; a < CHART_LEN; a++) begin
            chart[a] = '0;
            if (a < 10)
                chart[a] = '{oct_down: 1'b0, oct_up: 1'b1, keys: 7'b1000000};
            else if (a >= 12 && a < RUN_C)
                chart[a] = '{oct_down: 1'b0, oct_up: 1'b1, keys: 7'b0100000};
        end
    endtask

    task automatic load_chart();
        for (int a = 0; a < CHART_LEN; a++) begin
            @(negedge prog_clk);
            load_en   = 1'b1;
            load_addr = ADDR_W'(a);
            load_note = chart[a];
        end
        @(negedge prog_clk);
        load_en = 1'b0;
    endtask

    // Write and restart attempts that a busy player must ignore
    task automatic poke_inputs(int addr);
        start     = 1'b1;
        load_en   = 1'b1;
        load_addr = ADDR_W'(addr);
        load_note = (chart[addr] == '0) ? 9'h001 : 9'h000;
        @(negedge prog_clk);
        start   = 1'b0;
        load_en = 1'b0;
    endtask

    task automatic play_run(logic use_auto, logic poke);
        int mode;
        auto_play = use_auto;
        @(negedge prog_clk);
        start = 1'b1;
        @(negedge prog_clk);
        start = 1'b0;
        for (int s = 0; s < CHART_LEN; s++)
            key_log[s] = '0;
        if (poke) begin
            wait_age(COUNT_TICKS * TICK_CYCLES);
            poke_inputs(7);
        end
        for (int s = 0; s < int'(note_total); s++) begin
            wait_age(PLAY0 + TICK_CYCLES * s + TICK_CYCLES / 2);
            mode = $urandom % 5;
            // Press a note 0 to 3 ticks early, or something wrong
            // Near the end, early presses wrap to the chart's opening notes
            if (mode < 4)
                keys = (s + mode < int'(note_total)) ? chart[s + mode]
                                                     : chart[s + mode - int'(note_total)];
            else
                keys = 9'($urandom);
            if (s == int'(note_total) - 1)
                keys = chart[0];
            key_log[s] = keys;
            if (poke && s == 4)
                poke_inputs(5);
        end
        while (!finished)
            @(negedge prog_clk);
        repeat (4) @(negedge prog_clk);
    endtask

    initial begin
        void'($urandom(32'h2685));
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_note  = '0;
        note_total = '0;
        start      = 1'b0;
        auto_play  = 1'b0;
        keys       = '0;
        repeat (8) @(posedge prog_clk);
        @(negedge prog_clk);
        rst = 1'b0;
        repeat (20) @(negedge prog_clk);
        make_random_chart();
        load_chart();
        note_total = TOTAL_W'(RUN_A);
        play_run(1'b0, 1'b1);
        // Replay of the same chart must see no trace of the ignored writes
        // or of the key history left by the previous run
        play_run(1'b0, 1'b0);
        make_tone_chart();
        load_chart();
        note_total = TOTAL_W'(RUN_C);
        play_run(1'b1, 1'b0);
        repeat (10) @(negedge prog_clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- chart_player.f
logic/chart_pkg.sv
logic/chart_mem.sv
logic/chart_mem_arbiter.sv
logic/play_sequencer.sv
logic/hit_judge.sv
logic/next_note_display.sv
logic/tone_gen.sv
logic/chart_player.sv
bench/chart_player_tb.sv
